//--- src/lsu_defs.svh
// Load/store subsystem parameters
// Widths, queue depth, PMP region count and register map
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data path
`define LSU_XLEN 32
`define LSU_FIFO_DEPTH 4
`define LSU_CREDIT_W 3

// PMP
`define LSU_NUM_REGIONS 4

// Register map
`define LSU_CSR_ADDR_W 6
`define LSU_CSR_REGION_STRIDE 4
`define LSU_CSR_BASE_OFS 0
`define LSU_CSR_TOP_OFS 1
`define LSU_CSR_PERM_OFS 2
`define LSU_CSR_PRIV 32
`define LSU_CSR_LOADS 33
`define LSU_CSR_STORES 34
`define LSU_CSR_FAULTS 35

`endif

//--- src/lsu_pkg.sv
// Load/store subsystem types
// Opcodes, sizes, errors, FSM states and the request/response structs
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

  typedef enum logic {
    LSU_LOAD  = 1'b0,
    LSU_STORE = 1'b1
  } lsu_op_e;

  // Same size encoding as the core data type
  typedef enum logic [1:0] {
    SIZE_WORD = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_BYTE = 2'd2
  } lsu_size_e;

  typedef enum logic {
    PRIV_U = 1'b0,
    PRIV_M = 1'b1
  } priv_lvl_e;

  typedef enum logic [1:0] {
    ERR_NONE       = 2'd0,
    ERR_MISALIGNED = 2'd1,
    ERR_PMP        = 2'd2,
    ERR_BUS        = 2'd3
  } rsp_err_e;

  typedef enum logic [1:0] {
    ST_IDLE        = 2'd0,
    ST_WAIT_GNT    = 2'd1,
    ST_WAIT_RVALID = 2'd2,
    ST_RESPOND     = 2'd3
  } lsu_state_e;

  typedef struct packed {
    lsu_op_e                op;
    lsu_size_e              size;
    logic                   sign_ext;
    logic [`LSU_XLEN-1:0]   addr;
    logic [`LSU_XLEN-1:0]   wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] rdata;
    rsp_err_e             err;
  } lsu_rsp_t;

  // Region covers base <= addr < top
  typedef struct packed {
    logic [`LSU_XLEN-1:0] base;
    logic [`LSU_XLEN-1:0] top;
    logic                 read;
    logic                 write;
  } pmp_region_t;

  typedef struct packed {
    logic load_gnt;
    logic store_gnt;
    logic pmp_fault;
  } perf_evt_t;

endpackage

`default_nettype wire

//--- src/lsu_req_fifo.sv
// Request queue in front of the load/store unit
// Circular buffer that returns one credit per popped entry
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_req_fifo import lsu_pkg::*; (
  input  logic     clk,
  input  logic     rst_ni,
  input  logic     push_i,
  input  lsu_req_t push_data_i,
  input  logic     pop_i,
  output logic     head_valid_o,
  output lsu_req_t head_o,
  output logic     credit_o
);

  localparam int unsigned PTR_W = $clog2(`LSU_FIFO_DEPTH);

  lsu_req_t                 mem_q [`LSU_FIFO_DEPTH];
  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [`LSU_CREDIT_W-1:0] count_q;
  logic                     full;
  logic                     credit_q;

  assign full         = (count_q == `LSU_CREDIT_W'(`LSU_FIFO_DEPTH));
  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];
  assign credit_o     = credit_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`LSU_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`LSU_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + `LSU_CREDIT_W'(push_i) - `LSU_CREDIT_W'(pop_i);
      // Credit goes back the cycle after the slot frees
      credit_q <= pop_i;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Upstream spent more credits than it was given
  assert property (@(posedge clk) disable iff (!rst_ni) !(push_i && full))
    else $error("request pushed into a full queue");

  assert property (@(posedge clk) disable iff (!rst_ni) !(pop_i && !head_valid_o))
    else $error("pop from an empty queue");

endmodule

`default_nettype wire

//--- src/lsu_csr_regs.sv
// Register block for the load/store subsystem
// PMP regions, privilege level and load/store/fault counters
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_csr_regs import lsu_pkg::*; (
  input  logic                               clk,
  input  logic                               rst_ni,
  input  logic                               cfg_we_i,
  input  logic [`LSU_CSR_ADDR_W-1:0]         cfg_addr_i,
  input  logic [`LSU_XLEN-1:0]               cfg_wdata_i,
  input  perf_evt_t                          perf_evt_i,
  output logic [`LSU_XLEN-1:0]               cfg_rdata_o,
  output pmp_region_t [`LSU_NUM_REGIONS-1:0] regions_o,
  output priv_lvl_e                          priv_o
);

  localparam int unsigned AW      = `LSU_CSR_ADDR_W;
  localparam int unsigned NUM_CNT = 3;

  pmp_region_t [`LSU_NUM_REGIONS-1:0] regions_q;
  priv_lvl_e                          priv_q;
  logic [`LSU_XLEN-1:0]               cnt_q   [NUM_CNT];
  logic [NUM_CNT-1:0]                 cnt_evt;

  function automatic logic [AW-1:0] region_addr(int unsigned idx, int unsigned ofs);
    return AW'(idx * `LSU_CSR_REGION_STRIDE + ofs);
  endfunction

  // Counter index 0 loads, 1 stores, 2 PMP faults
  function automatic logic [AW-1:0] cnt_addr(int unsigned k);
    case (k)
      0:       return AW'(`LSU_CSR_LOADS);
      1:       return AW'(`LSU_CSR_STORES);
      default: return AW'(`LSU_CSR_FAULTS);
    endcase
  endfunction

  assign regions_o = regions_q;
  assign priv_o    = priv_q;

  assign cnt_evt = {perf_evt_i.pmp_fault, perf_evt_i.store_gnt, perf_evt_i.load_gnt};

  //////////////////////////////
  // PMP and privilege
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `LSU_NUM_REGIONS; i++) begin
        regions_q[i] <= '0;
      end
      priv_q <= PRIV_M;
    end else if (cfg_we_i) begin
      for (int i = 0; i < `LSU_NUM_REGIONS; i++) begin
        if (cfg_addr_i == region_addr(i, `LSU_CSR_BASE_OFS)) begin
          regions_q[i].base <= cfg_wdata_i;
        end
        if (cfg_addr_i == region_addr(i, `LSU_CSR_TOP_OFS)) begin
          regions_q[i].top <= cfg_wdata_i;
        end
        // Bit 0 read, bit 1 write
        if (cfg_addr_i == region_addr(i, `LSU_CSR_PERM_OFS)) begin
          regions_q[i].read  <= cfg_wdata_i[0];
          regions_q[i].write <= cfg_wdata_i[1];
        end
      end
      if (cfg_addr_i == AW'(`LSU_CSR_PRIV)) begin
        priv_q <= priv_lvl_e'(cfg_wdata_i[0]);
      end
    end
  end

  //////////////////////////////
  // Performance counters
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < NUM_CNT; k++) begin
        cnt_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < NUM_CNT; k++) begin
        // Host write beats a same-cycle event
        if (cfg_we_i && cfg_addr_i == cnt_addr(k)) begin
          cnt_q[k] <= cfg_wdata_i;
        end else if (cnt_evt[k]) begin
          cnt_q[k] <= cnt_q[k] + 1'b1;
        end
      end
    end
  end

  // Read mux, unmapped addresses give 0
  always_comb begin
    cfg_rdata_o = '0;
    for (int i = 0; i < `LSU_NUM_REGIONS; i++) begin
      if (cfg_addr_i == region_addr(i, `LSU_CSR_BASE_OFS)) begin
        cfg_rdata_o = regions_q[i].base;
      end
      if (cfg_addr_i == region_addr(i, `LSU_CSR_TOP_OFS)) begin
        cfg_rdata_o = regions_q[i].top;
      end
      if (cfg_addr_i == region_addr(i, `LSU_CSR_PERM_OFS)) begin
        cfg_rdata_o = {{(`LSU_XLEN-2){1'b0}}, regions_q[i].write, regions_q[i].read};
      end
    end
    if (cfg_addr_i == AW'(`LSU_CSR_PRIV)) begin
      cfg_rdata_o = {{(`LSU_XLEN-1){1'b0}}, priv_q};
    end
    for (int k = 0; k < NUM_CNT; k++) begin
      if (cfg_addr_i == cnt_addr(k)) begin
        cfg_rdata_o = cnt_q[k];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/pmp_checker.sv
// Physical memory protection check for the data access
// Lowest matching base/top region decides in user mode
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module pmp_checker import lsu_pkg::*; (
  input  logic [`LSU_XLEN-1:0]               addr_i,
  input  lsu_op_e                            op_i,
  input  pmp_region_t [`LSU_NUM_REGIONS-1:0] regions_i,
  input  priv_lvl_e                          priv_i,
  output logic                               allowed_o
);

  logic [`LSU_NUM_REGIONS-1:0] region_hit;
  logic [`LSU_NUM_REGIONS-1:0] region_perm;
  logic                        matched;
  logic                        perm_ok;

  // Per-region range match and permission for this op
  for (genvar i = 0; i < `LSU_NUM_REGIONS; i++) begin : g_region
    assign region_hit[i]  = (addr_i >= regions_i[i].base) && (addr_i < regions_i[i].top);
    assign region_perm[i] = (op_i == LSU_LOAD) ? regions_i[i].read : regions_i[i].write;
  end

  // First hit from index 0 wins
  always_comb begin
    matched = 1'b0;
    perm_ok = 1'b0;
    for (int i = 0; i < `LSU_NUM_REGIONS; i++) begin
      if (!matched && region_hit[i]) begin
        matched = 1'b1;
        perm_ok = region_perm[i];
      end
    end
  end

  // Machine mode bypasses the regions
  assign allowed_o = (priv_i == PRIV_M) || (matched && perm_ok);

endmodule

`default_nettype wire

//--- src/load_store_unit.sv
// Load/store unit on the req/gnt/rvalid/err data bus
// Aligns byte lanes, extends load data and reports access errors
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module load_store_unit import lsu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_ni,
  input  logic                       head_valid_i,
  input  lsu_req_t                   head_i,
  input  logic                       allowed_i,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic [`LSU_XLEN-1:0]       data_rdata_i,
  input  logic                       data_err_i,
  output logic                       pop_o,
  output logic [`LSU_XLEN-1:0]       chk_addr_o,
  output lsu_op_e                    chk_op_o,
  output logic                       data_req_o,
  output logic [`LSU_XLEN-1:0]       data_addr_o,
  output logic                       data_we_o,
  output logic [`LSU_XLEN/8-1:0]     data_be_o,
  output logic [`LSU_XLEN-1:0]       data_wdata_o,
  output logic                       rsp_valid_o,
  output lsu_rsp_t                   rsp_o,
  output perf_evt_t                  perf_evt_o
);

  localparam int unsigned BE_W  = `LSU_XLEN / 8;
  localparam int unsigned OFS_W = $clog2(BE_W);

  lsu_state_e            state_q;
  lsu_state_e            state_d;
  lsu_req_t              req_q;
  lsu_rsp_t              rsp_q;
  logic                  misaligned;
  rsp_err_e              early_err;
  logic [OFS_W-1:0]      offset;
  logic [BE_W-1:0]       be_base;
  logic [`LSU_XLEN-1:0]  rdata_shift;
  logic [`LSU_XLEN-1:0]  load_data;

  // The head is checked while it waits
  assign chk_addr_o = head_i.addr;
  assign chk_op_o   = head_i.op;

  always_comb begin
    case (head_i.size)
      SIZE_WORD: misaligned = |head_i.addr[OFS_W-1:0];
      SIZE_HALF: misaligned = head_i.addr[0];
      default:   misaligned = 1'b0;
    endcase
  end

  // Misalignment takes priority over PMP
  assign early_err = misaligned ? ERR_MISALIGNED : (allowed_i ? ERR_NONE : ERR_PMP);
  assign pop_o     = (state_q == ST_IDLE) && head_valid_i;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (pop_o) begin
          state_d = (early_err != ERR_NONE) ? ST_RESPOND : ST_WAIT_GNT;
        end
      end
      ST_WAIT_GNT: begin
        if (data_gnt_i) begin
          state_d = ST_WAIT_RVALID;
        end
      end
      ST_WAIT_RVALID: begin
        if (data_rvalid_i) begin
          state_d = ST_RESPOND;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // Bus side
  //////////////////////////////

  assign offset = req_q.addr[OFS_W-1:0];

  always_comb begin
    case (req_q.size)
      SIZE_WORD: be_base = '1;
      SIZE_HALF: be_base = BE_W'(2'b11);
      default:   be_base = BE_W'(1'b1);
    endcase
  end

  assign data_req_o   = (state_q == ST_WAIT_GNT);
  assign data_addr_o  = {req_q.addr[`LSU_XLEN-1:OFS_W], {OFS_W{1'b0}}};
  assign data_we_o    = (req_q.op == LSU_STORE);
  assign data_be_o    = be_base << offset;
  assign data_wdata_o = req_q.wdata << {offset, 3'b000};

  // Bring the addressed lanes down to bit 0, then extend
  assign rdata_shift = data_rdata_i >> {offset, 3'b000};

  always_comb begin
    case (req_q.size)
      SIZE_WORD: load_data = rdata_shift;
      SIZE_HALF: load_data = {{(`LSU_XLEN-16){req_q.sign_ext & rdata_shift[15]}},
                              rdata_shift[15:0]};
      default:   load_data = {{(`LSU_XLEN-8){req_q.sign_ext & rdata_shift[7]}},
                              rdata_shift[7:0]};
    endcase
  end

  // Request and response payload
  always_ff @(posedge clk) begin
    if (pop_o) begin
      req_q       <= head_i;
      rsp_q.rdata <= '0;
      rsp_q.err   <= early_err;
    end else if (state_q == ST_WAIT_RVALID && data_rvalid_i) begin
      rsp_q.rdata <= (data_err_i || req_q.op == LSU_STORE) ? '0 : load_data;
      rsp_q.err   <= data_err_i ? ERR_BUS : ERR_NONE;
    end
  end

  assign rsp_valid_o = (state_q == ST_RESPOND);
  assign rsp_o       = rsp_q;

  assign perf_evt_o = '{
    load_gnt:  data_req_o & data_gnt_i & ~data_we_o,
    store_gnt: data_req_o & data_gnt_i & data_we_o,
    pmp_fault: pop_o & (early_err == ERR_PMP)
  };

  // Bus request must hold until granted
  assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
      $stable(data_we_o) && $stable(data_be_o) && $stable(data_wdata_o))
    else $error("data request changed before grant");

endmodule

`default_nettype wire

//--- src/lsu_top.sv
// Standalone load/store subsystem
// Request queue, load/store unit, PMP check and register block
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_ni,
  // Request side
  input  logic                       req_valid_i,
  input  lsu_req_t                   req_i,
  output logic                       credit_o,
  // Register port
  input  logic                       cfg_we_i,
  input  logic [`LSU_CSR_ADDR_W-1:0] cfg_addr_i,
  input  logic [`LSU_XLEN-1:0]       cfg_wdata_i,
  output logic [`LSU_XLEN-1:0]       cfg_rdata_o,
  // Data bus
  output logic                       data_req_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  output logic [`LSU_XLEN-1:0]       data_addr_o,
  output logic                       data_we_o,
  output logic [`LSU_XLEN/8-1:0]     data_be_o,
  output logic [`LSU_XLEN-1:0]       data_wdata_o,
  input  logic [`LSU_XLEN-1:0]       data_rdata_i,
  input  logic                       data_err_i,
  // Response side
  output logic                       rsp_valid_o,
  output lsu_rsp_t                   rsp_o
);

  logic                               head_valid;
  lsu_req_t                           head;
  logic                               pop;
  logic [`LSU_XLEN-1:0]               chk_addr;
  lsu_op_e                            chk_op;
  logic                               allowed;
  pmp_region_t [`LSU_NUM_REGIONS-1:0] regions;
  priv_lvl_e                          priv;
  perf_evt_t                          perf_evt;

  lsu_req_fifo u_req_fifo (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .push_i       (req_valid_i),
    .push_data_i  (req_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_o       (head),
    .credit_o     (credit_o)
  );

  lsu_csr_regs u_csr_regs (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .perf_evt_i  (perf_evt),
    .cfg_rdata_o (cfg_rdata_o),
    .regions_o   (regions),
    .priv_o      (priv)
  );

  pmp_checker u_pmp_checker (
    .addr_i    (chk_addr),
    .op_i      (chk_op),
    .regions_i (regions),
    .priv_i    (priv),
    .allowed_o (allowed)
  );

  load_store_unit u_lsu (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .head_valid_i  (head_valid),
    .head_i        (head),
    .allowed_i     (allowed),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_err_i    (data_err_i),
    .pop_o         (pop),
    .chk_addr_o    (chk_addr),
    .chk_op_o      (chk_op),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .perf_evt_o    (perf_evt)
  );

endmodule

`default_nettype wire

//--- tb/tb_lsu_top.sv
// Testbench for the load/store subsystem
// Random requests against a bus memory model, a reference model and register copies
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module tb_lsu_top import lsu_pkg::*; ();

  localparam int TIMEOUT = 400;
  localparam int DEPTH   = `LSU_FIFO_DEPTH;

  logic                       clk;
  logic                       rst_ni;
  logic                       req_valid_i;
  lsu_req_t                   req_i;
  logic                       credit_o;
  logic                       cfg_we_i;
  logic [`LSU_CSR_ADDR_W-1:0] cfg_addr_i;
  logic [`LSU_XLEN-1:0]       cfg_wdata_i;
  logic [`LSU_XLEN-1:0]       cfg_rdata_o;
  logic                       data_req_o;
  logic                       data_gnt_i;
  logic                       data_rvalid_i;
  logic [`LSU_XLEN-1:0]       data_addr_o;
  logic                       data_we_o;
  logic [3:0]                 data_be_o;
  logic [`LSU_XLEN-1:0]       data_wdata_o;
  logic [`LSU_XLEN-1:0]       data_rdata_i;
  logic                       data_err_i;
  logic                       rsp_valid_o;
  lsu_rsp_t                   rsp_o;

  lsu_top DUT (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .credit_o      (credit_o),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .cfg_rdata_o   (cfg_rdata_o),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i),
    .data_err_i    (data_err_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // Model state
  //////////////////////////////

  logic [31:0] rng_state;
  logic [31:0] bus_rng_state;
  string       cur_test;
  int          err_cnt;
  int          test_err_base;
  int          tests_run;
  int          tests_failed;
  int          sent_cnt;
  int          ret_cnt;

  // Expected responses and expected bus accesses, both in request order
  lsu_rsp_t    exp_rsp_q [$];
  logic [31:0] exp_addr_q [$];
  logic        exp_we_q [$];
  logic [3:0]  exp_be_q [$];
  logic [31:0] exp_wdata_q [$];

  logic [31:0] model_mem [logic [31:0]];
  logic [31:0] bus_mem [logic [31:0]];

  // Register copies
  logic [31:0] m_base [`LSU_NUM_REGIONS];
  logic [31:0] m_top [`LSU_NUM_REGIONS];
  logic        m_rd [`LSU_NUM_REGIONS];
  logic        m_wr [`LSU_NUM_REGIONS];
  logic        m_priv;
  logic [31:0] m_loads;
  logic [31:0] m_stores;
  logic [31:0] m_faults;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Bus delays and error data draw from their own stream
  function automatic logic [31:0] next_bus_rand();
    bus_rng_state = xorshift(bus_rng_state);
    return bus_rng_state;
  endfunction

  // Unwritten words hold a pattern of their full address
  function automatic logic [31:0] fill_word(logic [31:0] waddr);
    return (waddr * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
  endfunction

  function automatic int credits();
    return DEPTH - sent_cnt + ret_cnt;
  endfunction

  function automatic logic model_allowed(logic [31:0] addr, lsu_op_e op);
    if (m_priv) begin
      return 1'b1;
    end
    for (int i = 0; i < `LSU_NUM_REGIONS; i++) begin
      if (addr >= m_base[i] && addr < m_top[i]) begin
        return (op == LSU_LOAD) ? m_rd[i] : m_wr[i];
      end
    end
    return 1'b0;
  endfunction

  task automatic abort(input string msg);
    $display("%s: %s", cur_test, msg);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  //////////////////////////////
  // Bus memory model
  //////////////////////////////

  initial begin
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] mask;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wd;
    int          gnt_dly;
    int          rv_dly;
    forever begin
      @(posedge clk);
      #1;
      if (rst_ni && data_req_o) begin
        addr = data_addr_o;
        we   = data_we_o;
        be   = data_be_o;
        wd   = data_wdata_o;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        assert (exp_addr_q.size() > 0) else begin
          $display("%s: bus request raised with no access expected", cur_test);
          err_cnt++;
        end
        if (exp_addr_q.size() > 0) begin
          assert (addr == exp_addr_q[0] && we == exp_we_q[0] && be == exp_be_q[0]) else begin
            $display("[ERROR] %s: bus addr/we/be expected %h/%b/%b actual %h/%b/%b",
                     cur_test, exp_addr_q[0], exp_we_q[0], exp_be_q[0], addr, we, be);
            err_cnt++;
          end
          if (we) begin
            assert ((wd & mask) == (exp_wdata_q[0] & mask)) else begin
              $display("[ERROR] %s: store lanes expected %h actual %h",
                       cur_test, exp_wdata_q[0] & mask, wd & mask);
              err_cnt++;
            end
          end
          void'(exp_addr_q.pop_front());
          void'(exp_we_q.pop_front());
          void'(exp_be_q.pop_front());
          void'(exp_wdata_q.pop_front());
        end
        gnt_dly = next_bus_rand() % 4;
        rv_dly  = 1 + next_bus_rand() % 3;
        repeat (gnt_dly) begin
          @(posedge clk);
          #1;
        end
        data_gnt_i = 1'b1;
        @(posedge clk);
        #1;
        data_gnt_i = 1'b0;
        repeat (rv_dly - 1) begin
          @(posedge clk);
          #1;
        end
        word = bus_mem.exists(addr) ? bus_mem[addr] : fill_word(addr);
        if (addr[15]) begin
          data_err_i   = 1'b1;
          data_rdata_i = next_bus_rand();
        end else begin
          data_err_i   = 1'b0;
          data_rdata_i = word;
          if (we) begin
            bus_mem[addr] = (word & ~mask) | (wd & mask);
          end
        end
        data_rvalid_i = 1'b1;
        @(posedge clk);
        #1;
        data_rvalid_i = 1'b0;
        data_err_i    = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Response and credit monitors
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_ni && credit_o) begin
      // A credit only comes back for a request that was sent
      assert (ret_cnt < sent_cnt) else begin
        $display("%s: credit returned with no request outstanding", cur_test);
        err_cnt++;
      end
      ret_cnt++;
    end
  end

  always @(posedge clk) begin
    if (rst_ni && rsp_valid_o) begin
      assert (exp_rsp_q.size() > 0) else begin
        $display("%s: response arrived with none outstanding", cur_test);
        err_cnt++;
      end
      if (exp_rsp_q.size() > 0) begin
        assert (rsp_o == exp_rsp_q[0]) else begin
          $display("[ERROR] %s: response expected %h/%0d actual %h/%0d", cur_test,
                   exp_rsp_q[0].rdata, exp_rsp_q[0].err, rsp_o.rdata, rsp_o.err);
          err_cnt++;
        end
        void'(exp_rsp_q.pop_front());
      end
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic issue(input lsu_op_e op, input lsu_size_e size, input logic sx,
                       input logic [31:0] addr, input logic [31:0] wd);
    lsu_rsp_t    e;
    logic        mis;
    int          n;
    int          ofs;
    int          t;
    logic [3:0]  be;
    logic [31:0] waddr;
    logic [31:0] word;
    logic [31:0] lanes;
    logic [31:0] val;
    n     = (size == SIZE_WORD) ? 4 : (size == SIZE_HALF) ? 2 : 1;
    ofs   = addr[1:0];
    waddr = {addr[31:2], 2'b00};
    mis   = (size == SIZE_WORD && addr[1:0] != 0) || (size == SIZE_HALF && addr[0]);
    e.rdata = '0;
    e.err   = ERR_NONE;
    if (mis) begin
      e.err = ERR_MISALIGNED;
    end else if (!model_allowed(addr, op)) begin
      e.err = ERR_PMP;
      m_faults++;
    end else begin
      be    = '0;
      lanes = '0;
      for (int k = 0; k < n; k++) begin
        be[ofs+k]            = 1'b1;
        lanes[8*(ofs+k) +: 8] = wd[8*k +: 8];
      end
      exp_addr_q.push_back(waddr);
      exp_we_q.push_back(op == LSU_STORE);
      exp_be_q.push_back(be);
      exp_wdata_q.push_back(lanes);
      if (op == LSU_STORE) begin
        m_stores++;
      end else begin
        m_loads++;
      end
      word = model_mem.exists(waddr) ? model_mem[waddr] : fill_word(waddr);
      if (addr[15]) begin
        e.err = ERR_BUS;
      end else if (op == LSU_STORE) begin
        for (int k = 0; k < n; k++) begin
          word[8*(ofs+k) +: 8] = wd[8*k +: 8];
        end
        model_mem[waddr] = word;
      end else begin
        val = '0;
        for (int k = 0; k < n; k++) begin
          val[8*k +: 8] = word[8*(ofs+k) +: 8];
        end
        if (sx && val[8*n-1]) begin
          for (int k = n; k < 4; k++) begin
            val[8*k +: 8] = 8'hFF;
          end
        end
        e.rdata = val;
      end
    end
    exp_rsp_q.push_back(e);
    t = 0;
    while (credits() == 0) begin
      @(posedge clk);
      #1;
      t++;
      if (t > TIMEOUT) begin
        abort("timed out waiting for a credit");
      end
    end
    req_valid_i   = 1'b1;
    req_i.op       = op;
    req_i.size     = size;
    req_i.sign_ext = sx;
    req_i.addr     = addr;
    req_i.wdata    = wd;
    sent_cnt++;
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  // Random aligned access inside [base, base+span)
  task automatic random_access(input logic [31:0] base, input int span);
    lsu_size_e   size;
    logic [31:0] addr;
    size = lsu_size_e'(next_rand() % 3);
    addr = base + next_rand() % span;
    if (size == SIZE_WORD) begin
      addr[1:0] = 2'b00;
    end else if (size == SIZE_HALF) begin
      addr[0] = 1'b0;
    end
    issue(lsu_op_e'(next_rand() & 1), size, next_rand() & 1, addr, next_rand());
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (exp_rsp_q.size() != 0) begin
      @(posedge clk);
      #1;
      t++;
      if (t > TIMEOUT) begin
        abort("timed out waiting for outstanding responses");
      end
    end
  endtask

  task automatic write_cfg(input int addr, input logic [31:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    if (addr < 4 * `LSU_NUM_REGIONS) begin
      case (addr % 4)
        0: m_base[addr/4] = data;
        1: m_top[addr/4] = data;
        2: begin
          m_rd[addr/4] = data[0];
          m_wr[addr/4] = data[1];
        end
        default: ;
      endcase
    end
    case (addr)
      `LSU_CSR_PRIV:   m_priv = data[0];
      `LSU_CSR_LOADS:  m_loads = data;
      `LSU_CSR_STORES: m_stores = data;
      `LSU_CSR_FAULTS: m_faults = data;
      default: ;
    endcase
    @(posedge clk);
    #1;
    cfg_we_i = 1'b0;
  endtask

  task automatic read_cfg(input int addr, input logic [31:0] exp_val);
    cfg_addr_i = addr;
    #1;
    assert (cfg_rdata_o == exp_val) else begin
      $display("[ERROR] %s: register %0d expected %h actual %h",
               cur_test, addr, exp_val, cfg_rdata_o);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
  endtask

  task automatic end_test();
    wait_idle();
    tests_run++;
    if (err_cnt != test_err_base) begin
      tests_failed++;
    end
    $display("%s: %0d errors", cur_test, err_cnt - test_err_base);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    clk           = 1'b0;
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_i         = '0;
    cfg_we_i      = 1'b0;
    cfg_addr_i    = '0;
    cfg_wdata_i   = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    data_err_i    = 1'b0;
    rng_state     = 32'd23;
    bus_rng_state = ~32'd23;
    err_cnt       = 0;
    tests_run     = 0;
    tests_failed  = 0;
    sent_cnt      = 0;
    ret_cnt       = 0;
    cur_test      = "reset";
    for (int i = 0; i < `LSU_NUM_REGIONS; i++) begin
      m_base[i] = '0;
      m_top[i]  = '0;
      m_rd[i]   = 1'b0;
      m_wr[i]   = 1'b0;
    end
    m_priv   = 1'b1;
    m_loads  = '0;
    m_stores = '0;
    m_faults = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_ni = 1'b1;

    start_test("reset_values");
    for (int a = 0; a < 36; a++) begin
      read_cfg(a, (a == `LSU_CSR_PRIV) ? 32'd1 : 32'd0);
    end
    end_test();

    start_test("machine_store_load");
    for (int i = 0; i < 40; i++) begin
      random_access(32'h0000_0100, 64);
    end
    end_test();

    start_test("misaligned");
    for (int i = 0; i < 12; i++) begin
      issue(lsu_op_e'(i & 1), SIZE_HALF, 1'b0, 32'h0000_0201 + 2 * i, next_rand());
      issue(lsu_op_e'(i & 1), SIZE_WORD, 1'b1, 32'h0000_0200 + 4 * i + 1 + i % 3, next_rand());
    end
    end_test();

    start_test("pmp_user_machine");
    write_cfg(0, 32'h0000_1000);
    write_cfg(1, 32'h0000_1100);
    write_cfg(2, 32'h1);
    write_cfg(4, 32'h0000_1000);
    write_cfg(5, 32'h0000_2000);
    write_cfg(6, 32'h3);
    write_cfg(8, 32'h0000_3000);
    write_cfg(9, 32'h0000_3100);
    write_cfg(10, 32'h2);
    for (int p = 0; p < 2; p++) begin
      write_cfg(`LSU_CSR_PRIV, p);
      for (int i = 0; i < 32; i++) begin
        random_access(32'h0000_1000 + (i % 4) * 32'h0000_0800 + (i % 4 == 3) * 32'h0800, 512);
      end
      wait_idle();
    end
    end_test();

    start_test("bus_error");
    for (int i = 0; i < 16; i++) begin
      random_access(32'h0000_8000 + (i % 2) * 32'h0000_8000, 128);
    end
    end_test();

    start_test("counters_credits");
    for (int i = 0; i < 60; i++) begin
      random_access(32'h0000_0100, 64);
    end
    wait_idle();
    read_cfg(`LSU_CSR_LOADS, m_loads);
    read_cfg(`LSU_CSR_STORES, m_stores);
    read_cfg(`LSU_CSR_FAULTS, m_faults);
    assert (credits() == DEPTH) else begin
      $display("[ERROR] %s: credits expected %0d actual %0d", cur_test, DEPTH, credits());
      err_cnt++;
    end
    write_cfg(`LSU_CSR_LOADS, 32'd0);
    read_cfg(`LSU_CSR_LOADS, 32'd0);
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+src
src/lsu_pkg.sv
src/lsu_req_fifo.sv
src/lsu_csr_regs.sv
src/pmp_checker.sv
src/load_store_unit.sv
src/lsu_top.sv
tb/tb_lsu_top.sv

//--- Bender.yml
package:
  name: lsu_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/lsu_pkg.sv
      - src/lsu_req_fifo.sv
      - src/lsu_csr_regs.sv
      - src/pmp_checker.sv
      - src/load_store_unit.sv
      - src/lsu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_lsu_top.sv
